//--- all.f
+incdir+verif
source/vis_cfg_pkg.sv
source/vis_bus_pkg.sv
source/correlator_bank.sv
source/vis_prefetch.sv
source/vis_buffer.sv
source/tart_vis_top.sv
verif/tb_tart_vis.sv

//--- source/correlator_bank.sv
module correlator_bank
   import vis_cfg_pkg::*;
   import vis_bus_pkg::*;
(
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic [2*NUM_ANT-1:0] smp_i,      // {q,i} per antenna, antenna 0 in the lsbs
   input  logic                 smp_vld_i,
   input  corr_req_t            req_i,
   output corr_rsp_t            rsp_o,
   output logic                 switch_o    // one cycle after the bank swap
);

   // two banks of accumulators, word 2p = real, 2p+1 = imag of pair p
   logic [WORD_W-1:0]             acc [2][NUM_WORD];
   logic                          act;          // bank currently integrating
   logic [$clog2(WINDOW_LEN)-1:0] cnt;          // valid samples in this window
   logic                          swap;

   logic [1:0] inc_re [NUM_PAIR];
   logic [1:0] inc_im [NUM_PAIR];

   // ------------------------------------------------
   // correlation rule, all pairs in parallel
   // ------------------------------------------------
   always_comb begin
      int p;
      logic ai, aq, bi, bq;
      p = 0;
      for (int a = 0; a < NUM_ANT; a++) begin
         for (int b = a + 1; b < NUM_ANT; b++) begin
            ai = smp_i[2*a];
            aq = smp_i[2*a+1];
            bi = smp_i[2*b];
            bq = smp_i[2*b+1];
            // agreement counts, each 0..2
            inc_re[p] = {1'b0, ai ~^ bi} + {1'b0, aq ~^ bq};
            inc_im[p] = {1'b0, aq ~^ bi} + {1'b0, ai ^ bq};   // 2nd term is disagreement
            p++;
         end
      end
   end

   // last sample of the window lands in the old bank, same edge swaps
   assign swap = smp_vld_i && (cnt == WINDOW_LEN - 1);

   // ------------------------------------------------
   // window counter, accumulate, bank swap
   // ------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         act      <= 1'b0;
         cnt      <= '0;
         switch_o <= 1'b0;
         for (int b = 0; b < 2; b++) begin
            for (int w = 0; w < NUM_WORD; w++) begin
               acc[b][w] <= '0;
            end
         end
      end else begin
         switch_o <= swap;                       // delayed one clock
         if (smp_vld_i) begin
            cnt <= swap ? '0 : cnt + 1'b1;
            for (int p = 0; p < NUM_PAIR; p++) begin
               acc[act][2*p]   <= acc[act][2*p]   + WORD_W'(inc_re[p]);
               acc[act][2*p+1] <= acc[act][2*p+1] + WORD_W'(inc_im[p]);
            end
         end
         if (swap) begin
            act <= ~act;
            // bank about to integrate starts from zero
            for (int w = 0; w < NUM_WORD; w++) begin
               acc[~act][w] <= '0;
            end
         end
      end
   end

   // ------------------------------------------------
   // read port, frozen bank only
   // ------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (req_i.stb) begin
         rsp_o.dat <= acc[~act][req_i.adr];      // 12..15 are unmapped
      end
      if (rst_i) begin
         rsp_o.ack <= 1'b0;
      end else begin
         rsp_o.ack <= req_i.stb;                 // fixed one-cycle latency
      end
   end

endmodule

//--- source/tart_vis_top.sv
module tart_vis_top
   import vis_cfg_pkg::*;
   import vis_bus_pkg::*;
(
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic [2*NUM_ANT-1:0] smp_i,
   input  logic                 smp_vld_i,
   input  host_req_t            host_req_i,
   output host_rsp_t            host_rsp_o,
   output logic                 available_o,
   output logic [WORD_W-1:0]    checksum_o
);

   logic      switch;     // bank swap pulse
   corr_req_t corr_req;   // prefetcher <-> correlators
   corr_rsp_t corr_rsp;
   buf_wr_t   buf_wr;     // prefetcher -> buffer

   // ------------------------------------------------
   // correlators, prefetch, buffer
   // ------------------------------------------------
   correlator_bank u_corr (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .smp_i     (smp_i),
      .smp_vld_i (smp_vld_i),
      .req_i     (corr_req),
      .rsp_o     (corr_rsp),
      .switch_o  (switch)
   );

   vis_prefetch u_prefetch (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .switch_i    (switch),
      .req_o       (corr_req),
      .rsp_i       (corr_rsp),
      .wr_o        (buf_wr),
      .available_o (available_o),
      .checksum_o  (checksum_o)
   );

   // host side reads bytes out of here
   vis_buffer u_buffer (
      .clk_i      (clk_i),
      .wr_i       (buf_wr),
      .host_req_i (host_req_i),
      .host_rsp_o (host_rsp_o)
   );

endmodule

//--- source/vis_buffer.sv
module vis_buffer
   import vis_cfg_pkg::*;
   import vis_bus_pkg::*;
(
   input  logic      clk_i,
   input  buf_wr_t   wr_i,         // 32-bit side from the prefetcher
   input  host_req_t host_req_i,   // 8-bit side for the host
   output host_rsp_t host_rsp_o
);

   logic [WORD_W-1:0] mem [NUM_WORD];

   logic [WADR_W-1:0] rd_word;
   logic [1:0]        rd_lane;
   logic [WORD_W-1:0] rd_data;

   // ------------------------------------------------
   // write port
   // ------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (wr_i.stb) begin
         mem[wr_i.adr] <= wr_i.dat;
      end
   end

   // ------------------------------------------------
   // host byte read
   // ------------------------------------------------
   // byte n -> word n/4, lane n mod 4, little-endian
   assign rd_word = host_req_i.adr[BADR_W-1:2];
   assign rd_lane = host_req_i.adr[1:0];
   assign rd_data = mem[rd_word];

   always_ff @(posedge clk_i) begin
      host_rsp_o.ack <= host_req_i.stb;   // follows strobe, low while host idles
      if (host_req_i.stb) begin
         host_rsp_o.dat <= rd_data[8*rd_lane +: 8];
      end
   end

endmodule

//--- source/vis_bus_pkg.sv
package vis_bus_pkg;
   import vis_cfg_pkg::*;

   // prefetcher -> correlators, one-cycle read strobe
   typedef struct packed {
      logic              stb;
      logic [WADR_W-1:0] adr;
   } corr_req_t;

   // correlators -> prefetcher, ack one cycle after stb
   typedef struct packed {
      logic              ack;
      logic [WORD_W-1:0] dat;
   } corr_rsp_t;

   // host byte port
   typedef struct packed {
      logic              stb;
      logic [BADR_W-1:0] adr;
   } host_req_t;

   typedef struct packed {
      logic       ack;
      logic [7:0] dat;
   } host_rsp_t;

   // prefetcher -> buffer write side
   typedef struct packed {
      logic              stb;
      logic [WADR_W-1:0] adr;
      logic [WORD_W-1:0] dat;
   } buf_wr_t;

   typedef enum logic [1:0] {
      PF_IDLE = 2'd0,   // waiting for a bank switch
      PF_REQ  = 2'd1,   // strobe out to the correlators
      PF_WAIT = 2'd2    // waiting on the ack
   } pf_state_e;

endpackage

//--- source/vis_cfg_pkg.sv
package vis_cfg_pkg;

   // ------------------------------------------------
   // array geometry
   // ------------------------------------------------
   localparam int NUM_ANT  = 4;                       // antennas, 2 sign bits each
   localparam int NUM_PAIR = NUM_ANT*(NUM_ANT-1)/2;   // unique pairs a < b
   localparam int NUM_WORD = 2*NUM_PAIR;              // real + imag per pair

   // visibility word and buffer addressing
   localparam int WORD_W = 32;
   localparam int WADR_W = 4;                         // word address, 12 of 16 used
   localparam int BADR_W = WADR_W + 2;                // byte address, 4 bytes per word

   // ------------------------------------------------
   // integration window
   // ------------------------------------------------
   // bank swaps after this many valid samples
   localparam int WINDOW_LEN = 64;

endpackage

//--- source/vis_prefetch.sv
module vis_prefetch
   import vis_cfg_pkg::*;
   import vis_bus_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              switch_i,      // banks just swapped
   output corr_req_t         req_o,
   input  corr_rsp_t         rsp_i,
   output buf_wr_t           wr_o,
   output logic              available_o,   // buffer holds a full window
   output logic [WORD_W-1:0] checksum_o
);

   pf_state_e         state;
   logic [WADR_W-1:0] wadr;                  // word being fetched
   logic              last_word;

   assign last_word = (wadr == WADR_W'(NUM_WORD - 1));

   // ------------------------------------------------
   // bus outputs
   // ------------------------------------------------
   always_comb begin
      req_o.stb = (state == PF_REQ);         // one cycle per word
      req_o.adr = wadr;

      // forward straight from the response, same cycle as ack
      wr_o.stb  = (state == PF_WAIT) && rsp_i.ack;
      wr_o.adr  = wadr;
      wr_o.dat  = rsp_i.dat;
   end

   // ------------------------------------------------
   // fetch FSM, two cycles per word
   // ------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state       <= PF_IDLE;
         wadr        <= '0;
         available_o <= 1'b0;
         checksum_o  <= '0;
      end else if (switch_i) begin
         // new window, also restarts a fetch in progress
         state       <= PF_REQ;
         wadr        <= '0;
         available_o <= 1'b0;
         checksum_o  <= '0;
      end else begin
         case (state)
            PF_IDLE: begin
               state <= PF_IDLE;             // hold until next switch
            end
            PF_REQ: begin
               state <= PF_WAIT;
            end
            PF_WAIT: begin
               if (rsp_i.ack) begin
                  checksum_o <= checksum_o + rsp_i.dat;   // mod 2^32 wrap
                  if (last_word) begin
                     state       <= PF_IDLE;
                     available_o <= 1'b1;
                  end else begin
                     wadr  <= wadr + 1'b1;
                     state <= PF_REQ;
                  end
               end
            end
            default: begin
               state <= PF_IDLE;
            end
         endcase
      end
   end

endmodule

//--- verif/tb_vis_model.svh
`ifndef TB_VIS_MODEL_SVH
`define TB_VIS_MODEL_SVH

// --------------------------------------------------
// reference model, lives inside the testbench module
// --------------------------------------------------
logic [31:0]       lfsr = 32'ha8da;     // fibonacci, taps 32 22 2 1
logic [WORD_W-1:0] cur_word [NUM_WORD]; // window being integrated
logic [WORD_W-1:0] exp_word [NUM_WORD]; // last finished window
logic [WORD_W-1:0] exp_sum = '0;        // checksum of exp_word
int                win_smp = 0;         // valid samples seen this window

// test bookkeeping
int n_err  = 0;
int n_pass = 0;
int n_fail = 0;

// one lfsr step per bit taken
function automatic logic next_bit();
   logic fb;
   fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
   lfsr = {lfsr[30:0], fb};
   return fb;
endfunction

function automatic void model_clear();
   for (int w = 0; w < NUM_WORD; w++) begin
      cur_word[w] = '0;
   end
   win_smp = 0;
endfunction

// one valid sample, done goes high on the sample that closes a window
function automatic void model_sample(input logic [2*NUM_ANT-1:0] s, output logic done);
   int   p;
   logic ai, aq, bi, bq;
   p    = 0;
   done = 1'b0;
   for (int a = 0; a < NUM_ANT; a++) begin
      for (int b = a + 1; b < NUM_ANT; b++) begin   // pairs (0,1) (0,2) .. (2,3)
         ai = s[2*a];
         aq = s[2*a+1];
         bi = s[2*b];
         bq = s[2*b+1];
         cur_word[2*p]   += WORD_W'(ai == bi) + WORD_W'(aq == bq);   // real
         cur_word[2*p+1] += WORD_W'(aq == bi) + WORD_W'(ai != bq);   // imag
         p++;
      end
   end
   win_smp++;
   if (win_smp == WINDOW_LEN) begin
      exp_word = cur_word;                  // frozen bank
      exp_sum  = '0;
      for (int w = 0; w < NUM_WORD; w++) begin
         exp_sum += exp_word[w];            // wraps mod 2^32
      end
      model_clear();                        // next bank starts at zero
      done = 1'b1;
   end
endfunction

// byte n is lane n mod 4 of word n/4, little-endian
function automatic logic [7:0] exp_byte(input int n);
   return exp_word[n/4][8*(n%4) +: 8];
endfunction

`endif

//--- verif/tb_tart_vis.sv
module tb_tart_vis
   import vis_cfg_pkg::*;
   import vis_bus_pkg::*;
();

   localparam int WIN_CYC     = 90;                     // bound per window
   localparam int READ_CYC    = 300;                    // host readouts
   localparam int TIMEOUT_CYC = 3*WIN_CYC + READ_CYC;
   localparam int NUM_WIN     = 3;
   localparam int NUM_BYTE    = 4*NUM_WORD;
   localparam int RISE_LAT    = 2 + 2*NUM_WORD;         // last sample drive -> available rise

   logic                 clk;
   logic                 rst;
   logic [2*NUM_ANT-1:0] smp;
   logic                 smp_vld;
   host_req_t            host_req;
   host_rsp_t            host_rsp;
   logic                 available;
   logic [WORD_W-1:0]    checksum;

   int cyc       = 0;   // posedges so far
   int drv_cyc   = 0;   // cycle the closing sample of a window was driven
   int win_drv   = 0;   // windows fully driven
   int read_done = 0;   // windows read back by the host

   `include "tb_vis_model.svh"

   tart_vis_top UUT (
      .clk_i       (clk),
      .rst_i       (rst),
      .smp_i       (smp),
      .smp_vld_i   (smp_vld),
      .host_req_i  (host_req),
      .host_rsp_o  (host_rsp),
      .available_o (available),
      .checksum_o  (checksum)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;   // period 40
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= TIMEOUT_CYC) begin
         $display("timeout reached after %0d cycles, results never completed", cyc);
         $display("TEST FAIL");
         $finish;
      end
   end

   // --------------------------------------------------
   // bus protocol assertions
   // --------------------------------------------------
   a_ack_follows: assert property (@(posedge clk) disable iff (rst)
      host_req.stb |=> host_rsp.ack)
      else begin
         $display("host ack missing one cycle after its strobe");
         n_err++;
      end

   a_no_stray_ack: assert property (@(posedge clk) disable iff (rst)
      host_rsp.ack |-> $past(host_req.stb))
      else begin
         $display("host ack seen without a strobe the cycle before");
         n_err++;
      end

   a_sum_holds: assert property (@(posedge clk) disable iff (rst)
      available && $past(available) |-> $stable(checksum))
      else begin
         $display("checksum_o changed while available_o stayed high");
         n_err++;
      end

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("ERROR %s got %h expected %h", name, got, exp);
         n_err++;
      end
   endtask

   task automatic report_test(input string name, input int e0);
      if (n_err == e0) begin
         n_pass++;
         $display("test %s passed", name);
      end else begin
         n_fail++;
         $display("test %s failed", name);
      end
   endtask

   // strobe every cycle, ack and byte of n-1 show up after edge n
   task automatic read_all();
      for (int n = 0; n <= NUM_BYTE; n++) begin
         @(posedge clk);
         host_req.stb <= (n < NUM_BYTE);
         host_req.adr <= BADR_W'(n);
         @(negedge clk);
         if (n > 0) begin
            check_val("host_rsp_o.ack", 32'(host_rsp.ack), 32'd1);
            check_val("host_rsp_o.dat", 32'(host_rsp.dat), 32'(exp_byte(n - 1)));
         end
      end
   endtask

   // --------------------------------------------------
   // samples, lfsr driven, ~1 in 4 cycles invalid
   // --------------------------------------------------
   initial begin : stimulus
      logic [2*NUM_ANT-1:0] s;
      logic                 v;
      logic                 done;
      model_clear();
      @(negedge rst);
      while (win_drv < NUM_WIN) begin
         @(posedge clk);
         for (int i = 0; i < 2*NUM_ANT; i++) begin
            s[i] = next_bit();
         end
         v = next_bit() | next_bit();
         if (win_smp == WINDOW_LEN - 1 && read_done < win_drv) begin
            v = 1'b0;                        // closing sample waits for the host readout
         end
         smp     <= s;
         smp_vld <= v;
         if (v) begin
            model_sample(s, done);
            if (done) begin
               drv_cyc = cyc + 1;
               win_drv++;
            end
         end
      end
      @(posedge clk);
      smp_vld <= 1'b0;
   end

   initial begin : main
      int    e0;
      string tag;
      rst      = 1'b1;
      smp      = '0;
      smp_vld  = 1'b0;
      host_req = '0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      e0 = n_err;
      check_val("available_o", 32'(available), 32'd0);
      check_val("host_rsp_o.ack", 32'(host_rsp.ack), 32'd0);
      check_val("checksum_o", checksum, 32'd0);
      report_test("reset values", e0);

      for (int w = 1; w <= NUM_WIN; w++) begin
         while (win_drv < w) @(negedge clk);
         tag = $sformatf("window %0d", w);
         e0  = n_err;
         @(negedge clk);
         if (w > 1) begin
            check_val("available_o", 32'(available), 32'd1);   // old results still up
         end
         @(negedge clk);                     // edge after switch clears both
         check_val("available_o", 32'(available), 32'd0);
         check_val("checksum_o", checksum, 32'd0);
         report_test({tag, " clear"}, e0);

         e0 = n_err;
         while (!available && cyc < drv_cyc + 30) @(negedge clk);
         if (!available) begin
            $display("available_o did not rise within 30 cycles of the window end");
            n_err++;
         end else begin
            assert (cyc - drv_cyc == RISE_LAT) else begin
               $display("available_o rose %0d cycles after the clearing edge, not %0d",
                        cyc - drv_cyc - 2, 2*NUM_WORD);
               n_err++;
            end
         end
         report_test({tag, " timing"}, e0);

         e0 = n_err;
         check_val("checksum_o", checksum, exp_sum);
         report_test({tag, " checksum"}, e0);

         e0 = n_err;
         read_all();
         report_test({tag, " readout"}, e0);
         read_done = w;                      // lets the next window close
      end

      $display("tests passed %0d failed %0d, errors %0d", n_pass, n_fail, n_err);
      if (n_err == 0 && n_fail == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule
